// File: hw/xif_config.svh
/* offload dispatcher configuration */

`ifndef XIF_CONFIG_SVH
`define XIF_CONFIG_SVH

////////////////////
// issue side
////////////////////

// source registers per offloaded instruction
`define XIF_RF_READ_PORTS 3

////////////////////
// memory side
////////////////////

// width of the outstanding load/store counter
`define XIF_MEM_CNT_W 4

`endif

// File: hw/xif_disp.sv
/* offload issue dispatcher */

`timescale 1ns/1ps

`include "xif_config.svh"

module xif_disp (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // decode stage
  input  logic                  instr_valid_i,
  input  logic                  xif_insn_dec_i,
  input  logic                  branch_or_jump_i,
  input  logic                  id_ready_i,
  input  xif_pkg::rs_vec_t      regs_used_i,
  input  xif_pkg::reg_addr_t    waddr_id_i,
  input  xif_pkg::priv_lvl_t    priv_lvl_i,
  // scoreboard and forwarding results
  input  xif_pkg::rs_vec_t      rs_busy_i,
  input  xif_pkg::rs_vec_t      rs_busy_dep_i,
  input  xif_pkg::rs_vec_t      ex_fwd_i,
  input  xif_pkg::rs_vec_t      wb_fwd_i,
  input  xif_pkg::rs_vec_t      rs_hazard_i,
  // issue response
  input  logic                  issue_ready_i,
  input  logic                  issue_accept_i,
  input  logic                  issue_writeback_i,
  input  logic                  issue_loadstore_i,
  // memory, result and control
  input  logic                  mem_valid_i,
  input  logic                  ex_ready_i,
  input  logic                  mem_instr_wb_i,
  input  logic                  wb_ready_i,
  input  logic                  data_req_dec_i,
  input  logic                  result_valid_i,
  input  logic                  ctrl_illegal_clr_i,
  // issue and commit
  output logic                  issue_valid_o,
  output logic                  commit_valid_o,
  output xif_pkg::rs_vec_t      rs_valid_o,
  output xif_pkg::xif_id_t      issue_id_o,
  output xif_pkg::xif_id_t      commit_id_o,
  output xif_pkg::xif_mode_t    issue_mode_o,
  // status
  output logic                  sb_set_o,
  output logic                  mem_ready_o,
  output logic                  mem_data_req_o,
  output logic                  mem_result_valid_o,
  output logic                  stall_o,
  output logic                  illegal_insn_o
);

  xif_pkg::xif_id_t           id_q;
  logic                       offloaded_q;
  logic                       illegal_q;
  logic [`XIF_MEM_CNT_W-1:0]  mem_cnt_q;
  logic                       issue_fire;
  logic                       ls_fire;
  logic                       fwd_block;
  logic                       illegal_n;
  logic                       dep;
  logic                       outstanding_mem;
  logic                       not_ready;
  logic                       mem_pending;

  ////////////////////
  // issue and commit
  ////////////////////

  // EX result would be lost if a coprocessor result lands now
  assign fwd_block = result_valid_i & (|ex_fwd_i);

  assign issue_valid_o = xif_insn_dec_i & instr_valid_i & ~branch_or_jump_i &
                         ~offloaded_q & ~fwd_block;
  assign issue_fire    = issue_valid_o & issue_ready_i;
  assign ls_fire       = issue_fire & issue_loadstore_i;
  assign rs_valid_o    = (~rs_busy_i | ex_fwd_i | wb_fwd_i) & ~rs_hazard_i;
  assign issue_id_o    = id_q;

  assign commit_valid_o = issue_valid_o;
  assign commit_id_o    = id_q;

  // mark the destination as pending in the scoreboard
  assign sb_set_o = issue_fire & issue_writeback_i;

  always_comb begin
    case (priv_lvl_i)
      xif_pkg::PRIV_LVL_M: issue_mode_o = 2'b11;
      xif_pkg::PRIV_LVL_H: issue_mode_o = 2'b10;
      xif_pkg::PRIV_LVL_S: issue_mode_o = 2'b01;
      xif_pkg::PRIV_LVL_U: issue_mode_o = 2'b00;
      default:             issue_mode_o = 2'b11;
    endcase
  end

  ////////////////////
  // memory channel
  ////////////////////

  assign mem_ready_o        = ex_ready_i;
  assign mem_data_req_o     = mem_valid_i & ex_ready_i;
  assign mem_result_valid_o = mem_instr_wb_i & wb_ready_i;

  ////////////////////
  // stall
  ////////////////////

  // coprocessor refused the instruction
  assign illegal_n = xif_insn_dec_i & instr_valid_i & ~offloaded_q &
                     issue_ready_i & ~issue_accept_i;

  assign dep             = ~illegal_n & (|(regs_used_i & rs_busy_dep_i));
  assign outstanding_mem = data_req_dec_i & (mem_cnt_q != '0);
  assign not_ready       = issue_valid_o & ~issue_ready_i;
  assign mem_pending     = mem_data_req_o & ~issue_fire;

  assign stall_o = dep | outstanding_mem | not_ready | mem_pending | fwd_block;

  assign illegal_insn_o = illegal_q;

  ////////////////////
  // state
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_q        <= '0;
      offloaded_q <= 1'b0;
      illegal_q   <= 1'b0;
      mem_cnt_q   <= '0;
    end else begin
      if (issue_fire) begin
        id_q <= id_q + 1'b1;
      end
      // held until decode moves on
      if (id_ready_i) begin
        offloaded_q <= 1'b0;
      end else if (issue_fire) begin
        offloaded_q <= 1'b1;
      end
      if (ctrl_illegal_clr_i) begin
        illegal_q <= 1'b0;
      end else if (illegal_n) begin
        illegal_q <= 1'b1;
      end
      // load/store issued but no memory request taken yet
      if (ls_fire && !mem_data_req_o) begin
        mem_cnt_q <= mem_cnt_q + 1'b1;
      end else if (!ls_fire && mem_data_req_o) begin
        mem_cnt_q <= mem_cnt_q - 1'b1;
      end
    end
  end

endmodule

// File: hw/xif_fwd_check.sv
/* forwarding and hazard check */

`timescale 1ns/1ps

`include "xif_config.svh"

module xif_fwd_check (
  // sources of the instruction in decode
  input  xif_pkg::reg_addr_t [`XIF_RF_READ_PORTS-1:0] rs_addr_i,
  // core write ports
  input  xif_pkg::reg_addr_t                           waddr_ex_i,
  input  xif_pkg::reg_addr_t                           waddr_wb_i,
  input  xif_pkg::reg_addr_t                           mem_waddr_ex_i,
  input  logic                                         we_ex_i,
  input  logic                                         we_wb_i,
  input  logic                                         mem_we_ex_i,
  input  logic                                         ex_valid_i,
  // per-source results
  output xif_pkg::rs_vec_t                             ex_fwd_o,
  output xif_pkg::rs_vec_t                             wb_fwd_o,
  output xif_pkg::rs_vec_t                             rs_hazard_o
);

  logic ex_wr;
  logic wb_wr;

  // forwarding only holds while EX carries a valid instruction
  assign ex_wr = we_ex_i & ex_valid_i;
  assign wb_wr = we_wb_i & ex_valid_i;

  ////////////////////
  // per source
  ////////////////////

  always_comb begin
    for (int i = 0; i < `XIF_RF_READ_PORTS; i++) begin
      ex_fwd_o[i] = ex_wr & (rs_addr_i[i] == waddr_ex_i);
      wb_fwd_o[i] = wb_wr & (rs_addr_i[i] == waddr_wb_i);

      // load data not there yet, or WB value without a forwarding path
      rs_hazard_o[i] = (mem_we_ex_i & (rs_addr_i[i] == mem_waddr_ex_i)) |
                       (~ex_valid_i & (rs_addr_i[i] == waddr_wb_i));
    end
  end

endmodule

// File: hw/xif_offload_top.sv
/* coprocessor offload top level */

`timescale 1ns/1ps

`include "xif_config.svh"

module xif_offload_top (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // decode stage
  input  logic                                         instr_valid_i,
  input  logic                                         xif_insn_dec_i,
  input  logic                                         branch_or_jump_i,
  input  logic                                         id_ready_i,
  input  xif_pkg::rs_vec_t                             regs_used_i,
  input  xif_pkg::reg_addr_t [`XIF_RF_READ_PORTS-1:0] rs_addr_i,
  input  xif_pkg::reg_addr_t                           waddr_id_i,
  input  xif_pkg::priv_lvl_t                           priv_lvl_i,
  // core write ports
  input  xif_pkg::reg_addr_t                           waddr_ex_i,
  input  xif_pkg::reg_addr_t                           waddr_wb_i,
  input  xif_pkg::reg_addr_t                           mem_waddr_ex_i,
  input  logic                                         we_ex_i,
  input  logic                                         we_wb_i,
  input  logic                                         mem_we_ex_i,
  input  logic                                         ex_valid_i,
  input  logic                                         ex_ready_i,
  input  logic                                         wb_ready_i,
  // issue channel
  output logic                                         issue_valid_o,
  input  logic                                         issue_ready_i,
  input  logic                                         issue_accept_i,
  input  logic                                         issue_writeback_i,
  input  logic                                         issue_loadstore_i,
  output xif_pkg::rs_vec_t                             rs_valid_o,
  output xif_pkg::xif_id_t                             issue_id_o,
  output xif_pkg::xif_mode_t                           issue_mode_o,
  // commit channel
  output logic                                         commit_valid_o,
  output xif_pkg::xif_id_t                             commit_id_o,
  // memory channel
  input  logic                                         mem_valid_i,
  output logic                                         mem_ready_o,
  output logic                                         mem_data_req_o,
  input  logic                                         mem_instr_wb_i,
  input  logic                                         data_req_dec_i,
  output logic                                         mem_result_valid_o,
  // result channel
  input  logic                                         result_valid_i,
  input  logic                                         result_we_i,
  input  xif_pkg::reg_addr_t                           result_rd_i,
  // status
  output xif_pkg::rs_vec_t                             ex_fwd_o,
  output xif_pkg::rs_vec_t                             wb_fwd_o,
  output logic                                         stall_o,
  output logic                                         illegal_insn_o,
  input  logic                                         ctrl_illegal_clr_i
);

  xif_pkg::rs_vec_t rs_busy;
  xif_pkg::rs_vec_t rs_busy_dep;
  xif_pkg::rs_vec_t rs_hazard;
  logic             sb_set;

  // pending coprocessor writes
  xif_scoreboard i_scoreboard (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .set_i          (sb_set),
    .set_addr_i     (waddr_id_i),
    .result_valid_i (result_valid_i),
    .result_we_i    (result_we_i),
    .result_rd_i    (result_rd_i),
    .rs_addr_i      (rs_addr_i),
    .rs_busy_o      (rs_busy),
    .rs_busy_dep_o  (rs_busy_dep)
  );

  // forwarding vectors go out and into the dispatcher
  xif_fwd_check i_fwd_check (
    .rs_addr_i      (rs_addr_i),
    .waddr_ex_i     (waddr_ex_i),
    .waddr_wb_i     (waddr_wb_i),
    .mem_waddr_ex_i (mem_waddr_ex_i),
    .we_ex_i        (we_ex_i),
    .we_wb_i        (we_wb_i),
    .mem_we_ex_i    (mem_we_ex_i),
    .ex_valid_i     (ex_valid_i),
    .ex_fwd_o       (ex_fwd_o),
    .wb_fwd_o       (wb_fwd_o),
    .rs_hazard_o    (rs_hazard)
  );

  xif_disp i_disp (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .xif_insn_dec_i     (xif_insn_dec_i),
    .branch_or_jump_i   (branch_or_jump_i),
    .id_ready_i         (id_ready_i),
    .regs_used_i        (regs_used_i),
    .waddr_id_i         (waddr_id_i),
    .priv_lvl_i         (priv_lvl_i),
    .rs_busy_i          (rs_busy),
    .rs_busy_dep_i      (rs_busy_dep),
    .ex_fwd_i           (ex_fwd_o),
    .wb_fwd_i           (wb_fwd_o),
    .rs_hazard_i        (rs_hazard),
    .issue_ready_i      (issue_ready_i),
    .issue_accept_i     (issue_accept_i),
    .issue_writeback_i  (issue_writeback_i),
    .issue_loadstore_i  (issue_loadstore_i),
    .mem_valid_i        (mem_valid_i),
    .ex_ready_i         (ex_ready_i),
    .mem_instr_wb_i     (mem_instr_wb_i),
    .wb_ready_i         (wb_ready_i),
    .data_req_dec_i     (data_req_dec_i),
    .result_valid_i     (result_valid_i),
    .ctrl_illegal_clr_i (ctrl_illegal_clr_i),
    .issue_valid_o      (issue_valid_o),
    .commit_valid_o     (commit_valid_o),
    .rs_valid_o         (rs_valid_o),
    .issue_id_o         (issue_id_o),
    .commit_id_o        (commit_id_o),
    .issue_mode_o       (issue_mode_o),
    .sb_set_o           (sb_set),
    .mem_ready_o        (mem_ready_o),
    .mem_data_req_o     (mem_data_req_o),
    .mem_result_valid_o (mem_result_valid_o),
    .stall_o            (stall_o),
    .illegal_insn_o     (illegal_insn_o)
  );

endmodule

// File: hw/xif_pkg.sv
/* offload dispatcher types */

`include "xif_config.svh"

package xif_pkg;

  // register file address
  typedef logic [4:0] reg_addr_t;

  // offload instruction id, wraps modulo 16
  typedef logic [3:0] xif_id_t;

  // core privilege level
  typedef logic [1:0] priv_lvl_t;

  localparam priv_lvl_t PRIV_LVL_M = 2'b11;
  localparam priv_lvl_t PRIV_LVL_H = 2'b10;
  localparam priv_lvl_t PRIV_LVL_S = 2'b01;
  localparam priv_lvl_t PRIV_LVL_U = 2'b00;

  // mode sent with the issue request
  typedef logic [1:0] xif_mode_t;

  // one bit per source port
  typedef logic [`XIF_RF_READ_PORTS-1:0] rs_vec_t;

endpackage

// File: hw/xif_scoreboard.sv
/* coprocessor write scoreboard */

`timescale 1ns/1ps

`include "xif_config.svh"

module xif_scoreboard (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // set from an accepted issue with writeback
  input  logic                                         set_i,
  input  xif_pkg::reg_addr_t                           set_addr_i,
  // clear from the result channel
  input  logic                                         result_valid_i,
  input  logic                                         result_we_i,
  input  xif_pkg::reg_addr_t                           result_rd_i,
  // lookups for the instruction in decode
  input  xif_pkg::reg_addr_t [`XIF_RF_READ_PORTS-1:0] rs_addr_i,
  output xif_pkg::rs_vec_t                             rs_busy_o,
  output xif_pkg::rs_vec_t                             rs_busy_dep_o
);

  logic [31:0] pending_q;
  logic [31:0] pending_d;
  logic        result_wr;
  logic        set_hit_by_result;

  assign result_wr = result_valid_i & result_we_i;

  // result for the same register arrives together with the issue
  assign set_hit_by_result = result_valid_i & (set_addr_i == result_rd_i) &
                             (result_rd_i != '0);

  ////////////////////
  // update
  ////////////////////

  always_comb begin
    pending_d = pending_q;
    if (set_i && !set_hit_by_result) begin
      pending_d[set_addr_i] = 1'b1;
    end
    if (result_wr) begin
      pending_d[result_rd_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  ////////////////////
  // lookup
  ////////////////////

  always_comb begin
    for (int i = 0; i < `XIF_RF_READ_PORTS; i++) begin
      rs_busy_o[i]     = pending_q[rs_addr_i[i]];
      // a result in flight for this register frees it already
      rs_busy_dep_o[i] = pending_q[rs_addr_i[i]] &
                         ~(result_wr & (result_rd_i == rs_addr_i[i]));
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the offload dispatcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_xif_offload
log=sim.log

verilator --binary --assert -j 0 --top-module "$top" -f xif_offload_top.f -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the result
grep -qF "*** TEST PASSED ***" "$log"
if [ $? -eq 0 ]; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1

// File: verif/tb_xif_offload.sv
/* offload dispatcher testbench */

`timescale 1ns/1ps

`include "xif_config.svh"

module tb_xif_offload;

  logic clk_i;
  logic rst_ni;
  logic instr_valid_i;
  logic xif_insn_dec_i;
  logic branch_or_jump_i;
  logic id_ready_i;
  logic we_ex_i;
  logic we_wb_i;
  logic mem_we_ex_i;
  logic ex_valid_i;
  logic ex_ready_i;
  logic wb_ready_i;
  logic issue_ready_i;
  logic issue_accept_i;
  logic issue_writeback_i;
  logic issue_loadstore_i;
  logic mem_valid_i;
  logic mem_instr_wb_i;
  logic data_req_dec_i;
  logic result_valid_i;
  logic result_we_i;
  logic ctrl_illegal_clr_i;
  xif_pkg::rs_vec_t regs_used_i;
  xif_pkg::reg_addr_t [`XIF_RF_READ_PORTS-1:0] rs_addr_i;
  xif_pkg::reg_addr_t waddr_id_i;
  xif_pkg::reg_addr_t waddr_ex_i;
  xif_pkg::reg_addr_t waddr_wb_i;
  xif_pkg::reg_addr_t mem_waddr_ex_i;
  xif_pkg::reg_addr_t result_rd_i;
  xif_pkg::priv_lvl_t priv_lvl_i;

  logic issue_valid_o;
  logic commit_valid_o;
  logic mem_ready_o;
  logic mem_data_req_o;
  logic mem_result_valid_o;
  logic stall_o;
  logic illegal_insn_o;
  xif_pkg::rs_vec_t rs_valid_o;
  xif_pkg::rs_vec_t ex_fwd_o;
  xif_pkg::rs_vec_t wb_fwd_o;
  xif_pkg::xif_id_t issue_id_o;
  xif_pkg::xif_id_t commit_id_o;
  xif_pkg::xif_mode_t issue_mode_o;

  logic [16:0] lfsr_q;
  int error_cnt;
  int test_base;
  int tests_ok;
  int tests_bad;

  xif_offload_top i_dut (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////
  // helpers
  ////////////////////

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // nonzero register with one LFSR step per bit
  task automatic rand_reg(output xif_pkg::reg_addr_t r);
    r = '0;
    while (r == '0) begin
      for (int b = 0; b < 5; b++) begin
        r = {r[3:0], lfsr_q[16]};
        lfsr_q = lfsr_next(lfsr_q);
      end
    end
  endtask

  function automatic xif_pkg::xif_mode_t expected_mode(input xif_pkg::priv_lvl_t p);
    case (p)
      xif_pkg::PRIV_LVL_M: return 2'd3;
      xif_pkg::PRIV_LVL_H: return 2'd2;
      xif_pkg::PRIV_LVL_S: return 2'd1;
      default:             return 2'd0;
    endcase
  endfunction

  task automatic check(input logic ok, input string msg);
    assert (ok) else begin
      $display("Error at %0t: %s", $time, msg);
      error_cnt++;
    end
  endtask

  // advance to 2 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  // just before the next rising edge
  task automatic sample();
    @(negedge clk_i);
    #8;
  endtask

  task automatic wait_issue(input string what);
    int n;
    n = 0;
    sample();
    while (!issue_valid_o && n < 20) begin
      step();
      sample();
      n++;
    end
    if (!issue_valid_o) begin
      $display("Timeout: issue valid never rose during %s", what);
      error_cnt++;
    end
  endtask

  task automatic wait_stall_clear(input string what);
    int n;
    n = 0;
    sample();
    while (stall_o && n < 20) begin
      step();
      sample();
      n++;
    end
    if (stall_o) begin
      $display("Timeout: stall never dropped during %s", what);
      error_cnt++;
    end
  endtask

  task automatic apply_defaults();
    instr_valid_i      = 1'b0;
    xif_insn_dec_i     = 1'b1;
    branch_or_jump_i   = 1'b0;
    id_ready_i         = 1'b1;
    regs_used_i        = '0;
    rs_addr_i          = '0;
    waddr_id_i         = '0;
    priv_lvl_i         = xif_pkg::PRIV_LVL_M;
    waddr_ex_i         = '0;
    waddr_wb_i         = '0;
    mem_waddr_ex_i     = '0;
    we_ex_i            = 1'b0;
    we_wb_i            = 1'b0;
    mem_we_ex_i        = 1'b0;
    ex_valid_i         = 1'b1;
    ex_ready_i         = 1'b1;
    wb_ready_i         = 1'b0;
    issue_ready_i      = 1'b1;
    issue_accept_i     = 1'b1;
    issue_writeback_i  = 1'b0;
    issue_loadstore_i  = 1'b0;
    mem_valid_i        = 1'b0;
    mem_instr_wb_i     = 1'b0;
    data_req_dec_i     = 1'b0;
    result_valid_i     = 1'b0;
    result_we_i        = 1'b0;
    result_rd_i        = '0;
    ctrl_illegal_clr_i = 1'b0;
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
  endtask

  // one accepted issue that writes back to rd
  task automatic issue_write(input xif_pkg::reg_addr_t rd);
    instr_valid_i     = 1'b1;
    issue_writeback_i = 1'b1;
    waddr_id_i        = rd;
    wait_issue("write issue");
    step();
    issue_writeback_i = 1'b0;
  endtask

  task automatic end_test(input string name);
    if (error_cnt == test_base) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: %0d errors", name, error_cnt - test_base);
      tests_bad++;
    end
    test_base = error_cnt;
  endtask

  ////////////////////
  // tests
  ////////////////////

  initial begin
    xif_pkg::reg_addr_t rd;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    lfsr_q    = 17'd69912;
    error_cnt = 0;
    test_base = 0;
    tests_ok  = 0;
    tests_bad = 0;
    apply_defaults();
    apply_reset();

    // scoreboard set and clear
    rand_reg(rd);
    issue_write(rd);
    regs_used_i  = 3'b001;
    rs_addr_i[0] = rd;
    sample();
    check(!rs_valid_o[0], $sformatf("busy x%0d reported valid", rd));
    check(stall_o, "no stall on a busy source");
    step();
    result_valid_i = 1'b1;
    result_we_i    = 1'b1;
    result_rd_i    = rd;
    sample();
    check(!stall_o, "stall held although the result frees the source");
    step();
    result_valid_i = 1'b0;
    result_we_i    = 1'b0;
    sample();
    check(rs_valid_o[0], $sformatf("x%0d still busy after its result", rd));
    step();
    apply_defaults();
    end_test("scoreboard");

    // EX and WB forwarding, result collision, load hazard
    rand_reg(rd);
    issue_write(rd);
    regs_used_i  = 3'b010;
    rs_addr_i[1] = rd;
    we_ex_i      = 1'b1;
    waddr_ex_i   = rd;
    sample();
    check(ex_fwd_o[1], "no EX forwarding on a matching source");
    check(rs_valid_o[1], "forwarded source reported invalid");
    step();
    we_ex_i    = 1'b0;
    we_wb_i    = 1'b1;
    waddr_wb_i = rd;
    sample();
    check(wb_fwd_o[1] && !ex_fwd_o[1], "no WB forwarding on a matching source");
    check(rs_valid_o[1], "WB-forwarded source reported invalid");
    step();
    we_wb_i        = 1'b0;
    we_ex_i        = 1'b1;
    result_valid_i = 1'b1;
    result_we_i    = 1'b1;
    result_rd_i    = rd;
    sample();
    check(!issue_valid_o, "issue valid while a result meets EX forwarding");
    check(stall_o, "no stall while a result meets EX forwarding");
    step();
    result_valid_i = 1'b0;
    result_we_i    = 1'b0;
    we_ex_i        = 1'b0;
    mem_we_ex_i    = 1'b1;
    mem_waddr_ex_i = rd;
    sample();
    check(!rs_valid_o[1], "load destination in EX not flagged");
    step();
    apply_defaults();
    end_test("forwarding");

    // id sequence and mode map from reset
    apply_reset();
    instr_valid_i = 1'b1;
    for (int k = 0; k < 20; k++) begin
      priv_lvl_i = xif_pkg::priv_lvl_t'(k);
      sample();
      check(issue_valid_o && commit_valid_o, "issue or commit valid low");
      check(issue_id_o == xif_pkg::xif_id_t'(k),
            $sformatf("issue id %0d, expected %0d", issue_id_o, k % 16));
      check(commit_id_o == xif_pkg::xif_id_t'(k),
            $sformatf("commit id %0d, expected %0d", commit_id_o, k % 16));
      check(issue_mode_o == expected_mode(priv_lvl_i),
            $sformatf("mode %0d for privilege %0d", issue_mode_o, priv_lvl_i));
      step();
    end
    apply_defaults();
    end_test("ids and mode");

    // back-pressure and then the offloaded flag
    instr_valid_i = 1'b1;
    issue_ready_i = 1'b0;
    id_ready_i    = 1'b0;
    repeat (2) begin
      sample();
      check(issue_valid_o, "issue valid dropped without ready");
      check(stall_o, "no stall while issue is not ready");
      step();
    end
    issue_ready_i = 1'b1;
    sample();
    check(issue_valid_o, "issue valid low when ready rises");
    step();
    sample();
    check(!issue_valid_o, "issue repeated before id_ready");
    step();
    id_ready_i = 1'b1;
    sample();
    check(!issue_valid_o, "offloaded flag cleared too early");
    step();
    id_ready_i = 1'b0;
    wait_issue("id_ready release");
    step();
    apply_defaults();
    end_test("offload flag");

    // refused issue
    instr_valid_i  = 1'b1;
    issue_accept_i = 1'b0;
    wait_issue("refused issue");
    check(!illegal_insn_o, "illegal raised in the refusal cycle");
    step();
    issue_accept_i = 1'b1;
    sample();
    check(illegal_insn_o, "illegal not raised after a refusal");
    step();
    ctrl_illegal_clr_i = 1'b1;
    sample();
    check(illegal_insn_o, "illegal cleared before the clear edge");
    step();
    ctrl_illegal_clr_i = 1'b0;
    sample();
    check(!illegal_insn_o, "illegal not cleared");
    step();
    apply_defaults();
    end_test("illegal");

    // two load/store offloads waiting for memory requests
    instr_valid_i     = 1'b1;
    issue_loadstore_i = 1'b1;
    step();
    step();
    instr_valid_i     = 1'b0;
    issue_loadstore_i = 1'b0;
    data_req_dec_i    = 1'b1;
    sample();
    check(stall_o, "no stall with outstanding memory offloads");
    step();
    mem_valid_i = 1'b1;
    ex_ready_i  = 1'b0;
    sample();
    check(!mem_data_req_o && !mem_ready_o, "memory request taken while EX not ready");
    check(stall_o, "stall dropped with requests still missing");
    step();
    ex_ready_i = 1'b1;
    repeat (2) begin
      sample();
      check(mem_data_req_o && mem_ready_o, "memory request not taken");
      step();
    end
    mem_valid_i = 1'b0;
    wait_stall_clear("memory counter drain");
    step();
    for (int j = 0; j < 4; j++) begin
      mem_instr_wb_i = j[0];
      wb_ready_i     = j[1];
      sample();
      check(mem_result_valid_o == (j[0] & j[1]),
            $sformatf("mem result valid %0b for wb %0b ready %0b",
                      mem_result_valid_o, j[0], j[1]));
      step();
    end
    apply_defaults();
    end_test("memory");

    $display("tests passed: %0d, failed: %0d", tests_ok, tests_bad);
    if (tests_bad == 0 && error_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: xif_offload_top.f
+incdir+hw
hw/xif_pkg.sv
hw/xif_scoreboard.sv
hw/xif_fwd_check.sv
hw/xif_disp.sv
hw/xif_offload_top.sv
verif/tb_xif_offload.sv
